/* logic/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    // datapath width
    localparam int xlen = 64;

    // multiplier split into identical shift-add stages
    localparam int mul_stage_bits = 16;
    localparam int mul_stages     = xlen / mul_stage_bits;

    // in-flight count spans the launch register plus every stage
    localparam int mul_cnt_bits = $clog2(mul_stages + 2);

    // operation codes
    typedef logic [4:0] exu_op_t;

    localparam exu_op_t op_add   = 5'd0;
    localparam exu_op_t op_sub   = 5'd1;
    localparam exu_op_t op_ret_a = 5'd2;
    localparam exu_op_t op_ret_b = 5'd3;
    localparam exu_op_t op_xor   = 5'd4;
    localparam exu_op_t op_or    = 5'd5;
    localparam exu_op_t op_and   = 5'd6;
    localparam exu_op_t op_sll   = 5'd7;
    localparam exu_op_t op_srl   = 5'd8;
    localparam exu_op_t op_sra   = 5'd9;
    localparam exu_op_t op_slt   = 5'd10;
    localparam exu_op_t op_sltu  = 5'd11;
    localparam exu_op_t op_eq    = 5'd12;
    localparam exu_op_t op_ge    = 5'd13;
    localparam exu_op_t op_geu   = 5'd14;
    localparam exu_op_t op_mul   = 5'd15;

    // operand a source
    localparam logic [1:0] sel_a_pc  = 2'd0;
    localparam logic [1:0] sel_a_rs1 = 2'd1;

    // operand b source
    localparam logic [1:0] sel_b_imm = 2'd0;
    localparam logic [1:0] sel_b_rs2 = 2'd1;
    localparam logic [1:0] sel_b_csr = 2'd2;

    // one operand seen as a double word or as two words
    // word[0] is the lower word
    typedef union packed {
        logic [xlen-1:0]  dword;
        logic [1:0][31:0] word;
    } exu_operand_u;

endpackage

`default_nettype wire

/* logic/exu_operand_sel.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_operand_sel (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic                     flush,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1,
    input  logic [exu_pkg::xlen-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0] csr,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  exu_pkg::exu_op_t         operate,
    input  logic [1:0]               sel_a,
    input  logic [1:0]               sel_b,
    input  logic                     rs1to32,
    input  logic                     stall,
    output logic [exu_pkg::xlen-1:0] a,
    output logic [exu_pkg::xlen-1:0] b,
    output exu_pkg::exu_op_t         op_q,
    output logic                     word_q,
    output logic                     alu_issue,
    output logic                     mul_in_valid,
    output logic [exu_pkg::xlen-1:0] mul_in_acc,
    output logic [exu_pkg::xlen-1:0] mul_in_mcand,
    output logic [exu_pkg::xlen-1:0] mul_in_mplier
);
    import exu_pkg::*;

    exu_operand_u rs1_u;
    logic         is_mul;

    // word mode drops the upper word of rs1
    always_comb begin
        rs1_u.dword = rs1;
        if (rs1to32) begin
            rs1_u.word[1] = '0;
        end
    end

    always_comb begin
        case (sel_a)
            sel_a_pc:  a = pc;
            sel_a_rs1: a = rs1_u.dword;
            default:   a = pc;
        endcase
    end

    always_comb begin
        case (sel_b)
            sel_b_imm: b = imm;
            sel_b_rs2: b = rs2;
            sel_b_csr: b = csr;
            default:   b = imm;
        endcase
    end

    assign op_q   = operate;
    assign word_q = rs1to32;
    assign is_mul = (operate == op_mul);

    // alu ops wait until every multiply has drained
    assign alu_issue = issue & ~flush & ~stall & ~is_mul;

    // launch register in front of stage 0
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_in_valid <= 1'b0;
        end else begin
            mul_in_valid <= issue & is_mul;
        end
    end

    always_ff @(posedge clk) begin
        if (issue && is_mul) begin
            mul_in_mcand  <= a;
            mul_in_mplier <= b;
        end
    end

    // accumulator starts from zero
    assign mul_in_acc = '0;

endmodule

`default_nettype wire

/* logic/exu_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_alu (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alu_issue,
    input  logic [exu_pkg::xlen-1:0] a,
    input  logic [exu_pkg::xlen-1:0] b,
    input  exu_pkg::exu_op_t         op_q,
    input  logic                     word_q,
    output logic [exu_pkg::xlen-1:0] alu_res,
    output logic                     alu_valid
);
    import exu_pkg::*;

    exu_operand_u    a_u;
    exu_operand_u    sra_w;
    logic [5:0]      shamt;
    logic [xlen-1:0] sra_d;
    logic [xlen-1:0] res_c;
    logic            lt_s;
    logic            lt_u;
    logic            eq;

    assign a_u.dword = a;
    assign shamt     = b[5:0];

    // full-width arithmetic shift
    assign sra_d = $signed(a) >>> shamt;

    // word shift on the lower word, upper word cleared
    always_comb begin
        sra_w.word[1] = '0;
        sra_w.word[0] = $signed(a_u.word[0]) >>> shamt;
    end

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;
    assign eq   = a == b;

    always_comb begin
        case (op_q)
            op_add: begin
                res_c = a + b;
            end
            op_sub: begin
                res_c = a - b;
            end
            op_ret_a: begin
                res_c = a;
            end
            op_ret_b: begin
                res_c = b;
            end
            op_xor: begin
                res_c = a ^ b;
            end
            op_or: begin
                res_c = a | b;
            end
            op_and: begin
                res_c = a & b;
            end
            op_sll: begin
                res_c = a << shamt;
            end
            op_srl: begin
                res_c = a >> shamt;
            end
            op_sra: begin
                res_c = word_q ? sra_w.dword : sra_d;
            end
            // comparisons return 0 or 1
            op_slt: begin
                res_c = {{(xlen-1){1'b0}}, lt_s};
            end
            op_sltu: begin
                res_c = {{(xlen-1){1'b0}}, lt_u};
            end
            op_eq: begin
                res_c = {{(xlen-1){1'b0}}, eq};
            end
            op_ge: begin
                res_c = {{(xlen-1){1'b0}}, ~lt_s};
            end
            op_geu: begin
                res_c = {{(xlen-1){1'b0}}, ~lt_u};
            end
            // mul goes through the stage pipeline
            default: begin
                res_c = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= alu_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_res <= res_c;
        end
    end

endmodule

`default_nettype wire

/* logic/exu_mul_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_mul_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     in_valid,
    input  logic [exu_pkg::xlen-1:0] in_acc,
    input  logic [exu_pkg::xlen-1:0] in_mcand,
    input  logic [exu_pkg::xlen-1:0] in_mplier,
    output logic                     out_valid,
    output logic [exu_pkg::xlen-1:0] out_acc,
    output logic [exu_pkg::xlen-1:0] out_mcand,
    output logic [exu_pkg::xlen-1:0] out_mplier
);
    import exu_pkg::*;

    logic [xlen-1:0] acc_c;

    // one partial product per low multiplier bit
    always_comb begin
        acc_c = in_acc;
        for (int i = 0; i < mul_stage_bits; i++) begin
            if (in_mplier[i]) begin
                acc_c = acc_c + (in_mcand << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // next stage sees the following 16 multiplier bits
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_acc    <= acc_c;
            out_mcand  <= in_mcand << mul_stage_bits;
            out_mplier <= in_mplier >> mul_stage_bits;
        end
    end

endmodule

`default_nettype wire

/* logic/exu_result_sel.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_result_sel (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     issue,
    input  exu_pkg::exu_op_t         operate,
    input  logic [exu_pkg::xlen-1:0] alu_res,
    input  logic                     alu_valid,
    input  logic                     mul_out_valid,
    input  logic [exu_pkg::xlen-1:0] mul_out_acc,
    output logic [exu_pkg::xlen-1:0] res,
    output logic                     res_valid,
    output logic                     alu_wait
);
    import exu_pkg::*;

    logic [mul_cnt_bits-1:0] mul_cnt;
    logic                    mul_issue;

    assign mul_issue = issue & (operate == op_mul);

    // multiplies between issue and completion
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_cnt <= '0;
        end else begin
            case ({mul_issue, mul_out_valid})
                2'b10: begin
                    mul_cnt <= mul_cnt + 1'b1;
                end
                2'b01: begin
                    mul_cnt <= mul_cnt - 1'b1;
                end
                default: begin
                    mul_cnt <= mul_cnt;
                end
            endcase
        end
    end

    // only a non-multiply op has to wait
    assign alu_wait = (mul_cnt != '0) & (operate != op_mul);

    // a completing multiply is dropped by flush
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= alu_valid | (mul_out_valid & ~flush);
        end
    end

    // the stall keeps both sources from landing together
    always_ff @(posedge clk) begin
        if (alu_valid) begin
            res <= alu_res;
        end else if (mul_out_valid) begin
            res <= mul_out_acc;
        end
    end

endmodule

`default_nettype wire

/* logic/exu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue,
    input  logic                     flush,
    input  logic [exu_pkg::xlen-1:0] pc,
    input  logic [exu_pkg::xlen-1:0] rs1,
    input  logic [exu_pkg::xlen-1:0] rs2,
    input  logic [exu_pkg::xlen-1:0] csr,
    input  logic [exu_pkg::xlen-1:0] imm,
    input  exu_pkg::exu_op_t         operate,
    input  logic [1:0]               sel_a,
    input  logic [1:0]               sel_b,
    input  logic                     rs1to32,
    output logic [exu_pkg::xlen-1:0] res,
    output logic                     res_valid,
    output logic                     alu_wait
);
    import exu_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    exu_op_t         op_q;
    logic            word_q;
    logic            alu_issue;
    logic [xlen-1:0] alu_res;
    logic            alu_valid;

    // index 0 is the launch, index mul_stages the last stage
    logic [mul_stages:0]           stg_valid;
    logic [mul_stages:0][xlen-1:0] stg_acc;
    logic [mul_stages:0][xlen-1:0] stg_mcand;
    logic [mul_stages:0][xlen-1:0] stg_mplier;

    exu_operand_sel u_operand_sel (
        .clk           (clk),
        .rst           (rst),
        .issue         (issue),
        .flush         (flush),
        .pc            (pc),
        .rs1           (rs1),
        .rs2           (rs2),
        .csr           (csr),
        .imm           (imm),
        .operate       (operate),
        .sel_a         (sel_a),
        .sel_b         (sel_b),
        .rs1to32       (rs1to32),
        .stall         (alu_wait),
        .a             (a),
        .b             (b),
        .op_q          (op_q),
        .word_q        (word_q),
        .alu_issue     (alu_issue),
        .mul_in_valid  (stg_valid[0]),
        .mul_in_acc    (stg_acc[0]),
        .mul_in_mcand  (stg_mcand[0]),
        .mul_in_mplier (stg_mplier[0])
    );

    exu_alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .alu_issue (alu_issue),
        .a         (a),
        .b         (b),
        .op_q      (op_q),
        .word_q    (word_q),
        .alu_res   (alu_res),
        .alu_valid (alu_valid)
    );

    genvar k;
    generate
        for (k = 0; k < mul_stages; k++) begin : g_stage
            exu_mul_stage u_stage (
                .clk        (clk),
                .rst        (rst),
                .flush      (flush),
                .in_valid   (stg_valid[k]),
                .in_acc     (stg_acc[k]),
                .in_mcand   (stg_mcand[k]),
                .in_mplier  (stg_mplier[k]),
                .out_valid  (stg_valid[k+1]),
                .out_acc    (stg_acc[k+1]),
                .out_mcand  (stg_mcand[k+1]),
                .out_mplier (stg_mplier[k+1])
            );
        end
    endgenerate

    exu_result_sel u_result_sel (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .issue         (issue),
        .operate       (operate),
        .alu_res       (alu_res),
        .alu_valid     (alu_valid),
        .mul_out_valid (stg_valid[mul_stages]),
        .mul_out_acc   (stg_acc[mul_stages]),
        .res           (res),
        .res_valid     (res_valid),
        .alu_wait      (alu_wait)
    );

endmodule

`default_nettype wire

/* sim/exu_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_assertions (
    input logic                            clk,
    input logic                            rst,
    input logic                            flush,
    input logic                            res_valid,
    input logic                            alu_wait,
    input logic                            alu_valid,
    input logic                            mul_out_valid,
    input logic [exu_pkg::mul_cnt_bits-1:0] mul_cnt
);
    int fail_count = 0;

    // outputs quiet right after a reset cycle
    reset_quiet: assert property (@(posedge clk) rst |=> (!res_valid && !alu_wait))
        else begin
            $error("res_valid or alu_wait high after reset");
            fail_count++;
        end

    // a flushed multiply never shows up
    flush_drop: assert property (@(posedge clk) disable iff (rst)
        $past(flush, 2) |-> !res_valid)
        else begin
            $error("res_valid high two cycles after flush");
            fail_count++;
        end

    // a stalled op never reaches the alu
    stall_block: assert property (@(posedge clk) disable iff (rst)
        alu_wait |=> !alu_valid)
        else begin
            $error("alu result produced for a stalled operation");
            fail_count++;
        end

    // every completing multiply is still counted as in flight
    count_live: assert property (@(posedge clk) disable iff (rst)
        mul_out_valid |-> (mul_cnt != '0))
        else begin
            $error("multiply completed while the in-flight count was zero");
            fail_count++;
        end

endmodule

bind exu_result_sel exu_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .res_valid     (res_valid),
    .alu_wait      (alu_wait),
    .alu_valid     (alu_valid),
    .mul_out_valid (mul_out_valid),
    .mul_cnt       (mul_cnt)
);

`default_nettype wire

/* sim/exu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int clk_half    = 50;
    localparam int drive_delay = 1;
    localparam int wait_limit  = 40;
    localparam int mul_latency = mul_stages + 1;

    logic            clk;
    logic            rst;
    logic            issue;
    logic            flush;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr;
    logic [xlen-1:0] imm;
    exu_op_t         operate;
    logic [1:0]      sel_a;
    logic [1:0]      sel_b;
    logic            rs1to32;
    logic [xlen-1:0] res;
    logic            res_valid;
    logic            alu_wait;

    int cyc_cnt      = 0;
    int mismatch_cnt = 0;
    int other_cnt    = 0;
    int timeout_cnt  = 0;

    // expected results, oldest first
    logic [xlen-1:0] exp_val[$];
    int              exp_due[$];
    int              exp_line[$];
    bit              exp_mul[$];

    exu_top exu_top_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .flush     (flush),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .operate   (operate),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .rs1to32   (rs1to32),
        .res       (res),
        .res_valid (res_valid),
        .alu_wait  (alu_wait)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // number of the latest rising edge
    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // each pulse must match the oldest expected entry, in its own cycle
    always @(negedge clk) begin : check_result
        logic [xlen-1:0] want;
        int              due;
        int              line_no;
        if (!rst && res_valid) begin
            if (exp_val.size() == 0) begin
                $display("unexpected res_valid at %0t with res %h", $time, res);
                other_cnt++;
            end else begin
                want    = exp_val.pop_front();
                due     = exp_due.pop_front();
                line_no = exp_line.pop_front();
                void'(exp_mul.pop_front());
                assert (res === want) else begin
                    $display("mismatch at %0t: line %0d gave %h, expected %h",
                             $time, line_no, res, want);
                    mismatch_cnt++;
                end
                assert (cyc_cnt == due) else begin
                    $display("result of line %0d came in cycle %0d instead of cycle %0d",
                             line_no, cyc_cnt, due);
                    other_cnt++;
                end
            end
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    // multiplies the unit still counts as in flight
    function automatic int pending_muls();
        int cnt;
        cnt = 0;
        foreach (exp_due[i]) begin
            if (exp_mul[i] && exp_due[i] > cyc_cnt) begin
                cnt++;
            end
        end
        return cnt;
    endfunction

    task automatic issue_line(input logic [3:0] mode, input exu_op_t op,
                              input logic [1:0] sa, input logic [1:0] sb, input logic w,
                              input logic [xlen-1:0] v_pc, input logic [xlen-1:0] v_rs1,
                              input logic [xlen-1:0] v_rs2, input logic [xlen-1:0] v_csr,
                              input logic [xlen-1:0] v_imm, input logic [xlen-1:0] v_exp,
                              input int line_no);
        bit want_wait;
        bit saw_wait;
        int waited;
        int cap;
        operate = op;
        sel_a   = sa;
        sel_b   = sb;
        rs1to32 = w;
        pc      = v_pc;
        rs1     = v_rs1;
        rs2     = v_rs2;
        csr     = v_csr;
        imm     = v_imm;
        issue   = 1'b1;
        want_wait = (op != op_mul) && (pending_muls() > 0);
        saw_wait  = 1'b0;
        waited    = 0;
        // inputs stay put while the unit stalls
        @(negedge clk);
        while (alu_wait && waited < wait_limit) begin
            saw_wait = 1'b1;
            waited++;
            @(negedge clk);
        end
        if (waited >= wait_limit) begin
            $display("timeout: alu_wait stayed high on line %0d", line_no);
            timeout_cnt++;
            issue = 1'b0;
        end else begin
            step_cycle();
            issue = 1'b0;
            cap   = cyc_cnt;
            assert (saw_wait == want_wait) else begin
                $display("alu_wait was %s on line %0d", saw_wait ? "seen" : "not seen",
                         line_no);
                other_cnt++;
            end
            if (mode != 4'd2) begin
                exp_val.push_back(v_exp);
                exp_due.push_back(cap + ((op == op_mul) ? mul_latency : 1));
                exp_line.push_back(line_no);
                exp_mul.push_back(op == op_mul);
            end
        end
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (exp_val.size() != 0 && waited < wait_limit) begin
            step_cycle();
            waited++;
        end
        if (exp_val.size() != 0) begin
            $display("timeout: %0d results never arrived", exp_val.size());
            timeout_cnt++;
        end
    endtask

    // cancel the multiply in its last stage and watch for stray results
    task automatic flush_pipeline();
        repeat (mul_latency - 2) step_cycle();
        flush = 1'b1;
        step_cycle();
        flush = 1'b0;
        repeat (mul_latency + 2) step_cycle();
    endtask

    initial begin : main_flow
        int              fd;
        int              n;
        int              line_no;
        int              gap;
        int              assert_cnt;
        string           text;
        logic [3:0]      f_mode;
        exu_op_t         f_op;
        logic [1:0]      f_sa;
        logic [1:0]      f_sb;
        logic            f_w;
        logic [xlen-1:0] f_pc;
        logic [xlen-1:0] f_rs1;
        logic [xlen-1:0] f_rs2;
        logic [xlen-1:0] f_csr;
        logic [xlen-1:0] f_imm;
        logic [xlen-1:0] f_exp;
        void'($urandom(32'h22ed11da));
        rst     = 1'b1;
        issue   = 1'b0;
        flush   = 1'b0;
        pc      = '0;
        rs1     = '0;
        rs2     = '0;
        csr     = '0;
        imm     = '0;
        operate = op_add;
        sel_a   = sel_a_pc;
        sel_b   = sel_b_imm;
        rs1to32 = 1'b0;
        repeat (2) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        fd = $fopen("sim/exu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/exu_golden.txt");
            other_cnt++;
        end else begin
            line_no = 0;
            while (!$feof(fd) && timeout_cnt == 0) begin
                n = $fgets(text, fd);
                line_no++;
                if (n > 0 && text.len() > 1 && text.getc(0) != "#") begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h", f_mode, f_op,
                                f_sa, f_sb, f_w, f_pc, f_rs1, f_rs2, f_csr, f_imm, f_exp);
                    if (n != 11) begin
                        $display("line %0d of the golden file is malformed", line_no);
                        other_cnt++;
                    end else begin
                        issue_line(f_mode, f_op, f_sa, f_sb, f_w, f_pc, f_rs1, f_rs2,
                                   f_csr, f_imm, f_exp, line_no);
                        if (f_mode == 4'd0) begin
                            wait_results();
                            gap = $urandom % 3;
                            repeat (gap) step_cycle();
                        end else if (f_mode == 4'd2) begin
                            flush_pipeline();
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (timeout_cnt == 0) begin
            wait_results();
        end
        repeat (3) step_cycle();
        assert_cnt = exu_top_i.u_result_sel.u_assertions.fail_count;
        $display("errors: %0d mismatch, %0d other, %0d timeout, %0d assertion",
                 mismatch_cnt, other_cnt, timeout_cnt, assert_cnt);
        if (mismatch_cnt + other_cnt + timeout_cnt + assert_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/exu_golden.txt */
# mode op sel_a sel_b rs1to32 pc rs1 rs2 csr imm expected, all hex
# mode 0 waits for results, 1 issues the next line at once, 2 flushes after issue
0 0 0 0 0 1000 5 7 9 24 1024
0 1 1 1 0 0 3 5 0 0 fffffffffffffffe
0 2 0 0 0 80000000 0 0 0 11 80000000
0 3 0 2 0 0 0 0 deadbeefcafef00d 0 deadbeefcafef00d
0 4 1 1 0 0 ff00ff00 0ff00ff0 0 0 f0f0f0f0
0 5 1 0 0 0 1200 0 0 34 1234
0 6 0 2 0 ffff0000ffff0000 0 0 123456789abcdef0 0 123400009abc0000
0 7 1 0 0 0 1 0 0 7f 8000000000000000
0 8 1 1 0 0 8000000000000000 4 0 0 0800000000000000
0 9 1 0 0 0 8000000000000000 0 0 4 f800000000000000
0 9 1 0 1 0 ffffffff80000000 0 0 4 f8000000
0 0 1 1 1 0 123456789 1 0 0 2345678a
0 a 1 1 0 0 ffffffffffffffff 1 0 0 1
0 b 1 1 0 0 ffffffffffffffff 1 0 0 0
0 c 0 2 0 40 0 0 40 0 1
0 d 1 0 0 0 5 0 0 fffffffffffffffb 1
0 e 1 0 0 0 5 0 0 fffffffffffffffb 0
0 f 1 1 0 0 ffffffffffffffff 3 0 0 fffffffffffffffd
0 f 0 0 0 1000 0 0 0 2 2000
1 f 1 1 0 0 3 1000100010001 0 0 3000300030003
1 f 1 1 0 0 100000001 100000003 0 0 400000003
1 f 1 1 0 0 8000000000000001 1000000000002 0 0 1000000000002
0 0 1 1 0 0 7 8 0 0 f
2 f 1 1 0 0 5 5 0 0 19
0 1 1 2 0 0 64 0 1 0 63

/* src.f */
logic/exu_pkg.sv
logic/exu_operand_sel.sv
logic/exu_alu.sv
logic/exu_mul_stage.sv
logic/exu_result_sel.sv
logic/exu_top.sv
sim/exu_assertions.sv
sim/exu_tb.sv

/* Makefile */
# Verilator build and run for the execute unit testbench

VERILATOR ?= verilator
TOP       ?= exu_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
